/* project.f */
verilog/replay_pkg.sv
verilog/pkt_writer.sv
verilog/pkt_reader.sv
verilog/mem_port_arbiter.sv
verilog/replay_buffer_top.sv
verification/replay_buffer_tb.sv

/* verification/replay_buffer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module replay_buffer_tb;

  localparam int EXP_DEPTH = 1024;

  logic                    clk;
  logic                    rst;
  replay_pkg::beat_t       in_beat;
  logic                    in_valid;
  logic                    in_ready;
  logic                    replay_en;
  replay_pkg::beat_t       out_beat;
  logic                    out_valid;
  logic                    out_ready;

  // Stimulus state and queue model
  integer            seed;
  integer            ready_seed;
  bit                bp_on;
  bit                expect_idle;
  int                beats_sent;
  int                cycles;
  int                fill [replay_pkg::NUM_QUEUES];
  int                kept_pkts [replay_pkg::NUM_QUEUES];
  int                got_pkts [replay_pkg::NUM_QUEUES];
  int                exp_wr [replay_pkg::NUM_QUEUES];
  int                exp_rd [replay_pkg::NUM_QUEUES];
  replay_pkg::beat_t exp_mem [replay_pkg::NUM_QUEUES][EXP_DEPTH];

  // Output side tracking
  bit                           held_valid;
  replay_pkg::beat_t            held_beat;
  bit                           in_pkt;
  logic [replay_pkg::QID_W-1:0] open_qid;

  replay_buffer_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .replay_en (replay_en),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #20 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_beat(input string name, input replay_pkg::beat_t got,
                            input replay_pkg::beat_t exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s = %h, expected %h", $time, name, got, exp);
      report_failure("Output beat differs from the reference");
    end
  endtask

  task automatic check_count(input logic [replay_pkg::QID_W-1:0] qid, input int got,
                             input int exp);
    if (got != exp) begin
      $display("Mismatch at time %0t: packet count of queue %0d = %0d, expected %0d",
               $time, qid, got, exp);
      report_failure("Packet totals differ from the reference");
    end
  endtask

  // Admission rule, room for a packet of the longest length
  function automatic bit predict_keep(input int used);
    return (replay_pkg::QUEUE_DEPTH - used) >= replay_pkg::MAX_PKT_BEATS;
  endfunction

  function automatic bit all_drained();
    bit done;
    done = 1'b1;
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      if (exp_rd[q] != exp_wr[q]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic send_packet(input logic [replay_pkg::QID_W-1:0] qid, input int len,
                             input bit wait_room, output bit kept);
    replay_pkg::beat_t beat;
    int                stalls;
    int                allowed;
    // Reader drains the queue, model fill never undercounts the DUT
    if (wait_room) begin
      while (!predict_keep(fill[qid])) begin
        @(posedge clk);
        #2;
      end
    end
    kept = predict_keep(fill[qid]);
    if (kept) begin
      kept_pkts[qid]++;
    end
    for (int i = 0; i < len; i++) begin
      beat.qid  = qid;
      beat.data = $random(seed);
      beat.last = (i == len - 1);
      in_beat   = beat;
      in_valid  = 1'b1;
      stalls    = 0;
      allowed   = (i == 0) ? 1 : 0;
      @(negedge clk);
      while (!in_ready) begin
        stalls++;
        if (stalls > allowed) begin
          report_failure("in_ready stayed low longer than the decision cycle");
        end
        @(negedge clk);
      end
      if (stalls != allowed) begin
        report_failure("First beat of a packet was taken without a decision cycle");
      end
      @(posedge clk);
      #2;
      beats_sent++;
      if (kept) begin
        exp_mem[qid][exp_wr[qid]] = beat;
        exp_wr[qid]++;
        fill[qid]++;
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (!all_drained()) begin
      @(posedge clk);
      #2;
    end
    repeat (4) @(posedge clk);
    #2;
  endtask

  task automatic send_random_packets(input int count);
    logic [replay_pkg::QID_W-1:0] qid;
    int                           len;
    bit                           kept;
    for (int n = 0; n < count; n++) begin
      qid = $unsigned($random(seed)) % replay_pkg::NUM_QUEUES;
      len = 1 + ($unsigned($random(seed)) % replay_pkg::MAX_PKT_BEATS);
      send_packet(qid, len, 1'b1, kept);
    end
  endtask

  // Random back-pressure on the output
  always @(posedge clk) begin
    #2;
    if (bp_on) begin
      out_ready = 1'($random(ready_seed));
    end else begin
      out_ready = 1'b1;
    end
  end

  // Output compare, sampled mid-cycle
  always @(negedge clk) begin : out_check
    logic [replay_pkg::QID_W-1:0] q;
    if (!rst) begin
      if (expect_idle && out_valid) begin
        report_failure("Output produced while replay was disabled");
      end
      if (held_valid) begin
        if (!out_valid) begin
          report_failure("out_valid dropped while the beat was stalled");
        end
        check_beat("out_beat (stalled)", out_beat, held_beat);
      end
      if (out_valid && out_ready) begin
        q = out_beat.qid;
        if (exp_rd[q] == exp_wr[q]) begin
          report_failure($sformatf("Unexpected output beat on queue %0d", q));
        end
        if (in_pkt && q != open_qid) begin
          report_failure("Packets from different queues interleaved at the output");
        end
        check_beat("out_beat", out_beat, exp_mem[q][exp_rd[q]]);
        exp_rd[q]++;
        fill[q]--;
        if (out_beat.last) begin
          got_pkts[q]++;
          in_pkt = 1'b0;
        end else begin
          in_pkt   = 1'b1;
          open_qid = q;
        end
      end
      held_valid = out_valid && !out_ready;
      held_beat  = out_beat;
    end
  end

  // Watchdog grows with the traffic sent
  always @(posedge clk) begin
    cycles++;
    if (cycles > beats_sent * 8 + 2000) begin
      report_failure("Timeout: the run made no progress in the allowed time");
    end
  end

  initial begin
    bit kept;
    clk         = 1'b0;
    rst         = 1'b1;
    in_beat     = '0;
    in_valid    = 1'b0;
    replay_en   = 1'b0;
    out_ready   = 1'b1;
    seed        = 32'hcd61bbf1;
    ready_seed  = 32'hcd61bbf1;
    bp_on       = 1'b0;
    expect_idle = 1'b0;
    beats_sent  = 0;
    cycles      = 0;
    held_valid  = 1'b0;
    in_pkt      = 1'b0;
    open_qid    = '0;
    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      fill[q]      = 0;
      kept_pkts[q] = 0;
      got_pkts[q]  = 0;
      exp_wr[q]    = 0;
      exp_rd[q]    = 0;
    end

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (in_ready || out_valid) begin
      report_failure("in_ready or out_valid high right after reset");
    end
    @(posedge clk);
    #2;

    // Packets on all queues with replay running
    replay_en = 1'b1;
    send_random_packets(24);
    wait_drained();

    // Fill queue 1 until the rule drops a packet
    replay_en   = 1'b0;
    expect_idle = 1'b1;
    do begin
      send_packet(2'd1, 1 + ($unsigned($random(seed)) % replay_pkg::MAX_PKT_BEATS),
                  1'b0, kept);
    end while (kept);
    // Other queues still take packets after the drop
    send_packet(2'd0, 5, 1'b0, kept);
    send_packet(2'd2, 16, 1'b0, kept);
    send_packet(2'd3, 1, 1'b0, kept);
    repeat (3) @(posedge clk);
    #2;
    expect_idle = 1'b0;
    replay_en   = 1'b1;
    wait_drained();

    // Random stalls on the output side
    bp_on = 1'b1;
    send_random_packets(24);
    wait_drained();
    bp_on = 1'b0;
    repeat (20) @(posedge clk);
    #2;

    for (int q = 0; q < replay_pkg::NUM_QUEUES; q++) begin
      check_count(q[replay_pkg::QID_W-1:0], got_pkts[q], kept_pkts[q]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/mem_port_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_port_arbiter (
  input  wire                          clk,
  input  wire replay_pkg::mem_wr_req_t wr_req,
  input  wire replay_pkg::mem_rd_req_t rd_req,
  output logic                         rd_grant,
  output replay_pkg::mem_word_t        rd_word
);

  // Four queue regions laid out by queue number
  replay_pkg::mem_word_t mem [2**replay_pkg::ADDR_W];

  // Writes always win the single port
  assign rd_grant = rd_req.valid && !wr_req.valid;

  always_ff @(posedge clk) begin
    if (wr_req.valid) begin
      mem[wr_req.addr] <= wr_req.word;
    end
  end

  // Registered read data, valid the cycle after grant
  always_ff @(posedge clk) begin
    if (rd_grant) begin
      rd_word <= mem[rd_req.addr];
    end
  end

endmodule

`default_nettype wire

/* verilog/pkt_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_reader (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        replay_en,
  input  wire replay_pkg::ptr_vec_t  tails,
  output replay_pkg::ptr_vec_t       heads,
  output replay_pkg::mem_rd_req_t    rd_req,
  input  wire                        rd_grant,
  input  wire replay_pkg::mem_word_t rd_word,
  output replay_pkg::beat_t          out_beat,
  output logic                       out_valid,
  input  wire                        out_ready
);

  logic                               pkt_open;
  logic                               rd_pending;
  logic [replay_pkg::QID_W-1:0]       cur_q;
  logic [replay_pkg::QID_W-1:0]       next_q;
  logic                               found;
  logic [replay_pkg::NUM_QUEUES-1:0]  nonempty;
  logic                               out_free;

  always_comb begin
    for (int i = 0; i < replay_pkg::NUM_QUEUES; i++) begin
      nonempty[i] = (heads[i] != tails[i]);
    end
  end

  // Round robin search starting after the queue served last
  always_comb begin : rr_pick
    logic [replay_pkg::QID_W-1:0] cand;
    found  = 1'b0;
    next_q = cur_q;
    cand   = cur_q;
    for (int i = 0; i < replay_pkg::NUM_QUEUES; i++) begin
      cand = cand + 1'b1;
      if (!found && nonempty[cand]) begin
        found  = 1'b1;
        next_q = cand;
      end
    end
  end

  // Output register is empty now or drains this cycle
  assign out_free = !out_valid || out_ready;

  always_comb begin
    rd_req.valid = pkt_open && !rd_pending && nonempty[cur_q] && out_free;
    rd_req.addr  = {cur_q, heads[cur_q][replay_pkg::OFFSET_W-1:0]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_open   <= 1'b0;
      rd_pending <= 1'b0;
      // Queue 0 comes first after reset
      cur_q      <= '1;
      heads      <= '0;
      out_valid  <= 1'b0;
    end else begin
      rd_pending <= rd_grant;
      if (rd_grant) begin
        heads[cur_q] <= heads[cur_q] + 1'b1;
      end

      if (!pkt_open) begin
        if (replay_en && found) begin
          pkt_open <= 1'b1;
          cur_q    <= next_q;
        end
      end else if (rd_pending && rd_word.last) begin
        // Last word is back, packet done
        pkt_open <= 1'b0;
      end

      if (rd_pending) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pending) begin
      out_beat.qid  <= cur_q;
      out_beat.data <= rd_word.data;
      out_beat.last <= rd_word.last;
    end
  end

  // Returning data always lands in an empty output register
  assert property (@(posedge clk) disable iff (rst)
    rd_pending |-> !out_valid)
    else $error("Read data arrived while the output register was full");

  // Stalled beat must hold until taken
  assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else $error("Output beat changed under back-pressure");

endmodule

`default_nettype wire

/* verilog/pkt_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_writer (
  input  wire                       clk,
  input  wire                       rst,
  input  wire replay_pkg::beat_t    in_beat,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire replay_pkg::ptr_vec_t heads,
  output replay_pkg::mem_wr_req_t   wr_req,
  output replay_pkg::ptr_vec_t      tails
);

  typedef enum logic [1:0] {
    ST_DECIDE,
    ST_STORE,
    ST_DROP
  } state_t;

  state_t                                         state;
  logic [replay_pkg::QID_W-1:0]                   cur_qid;
  logic [replay_pkg::PTR_W-1:0]                   used_words;
  logic [replay_pkg::PTR_W-1:0]                   cur_used;
  logic                                           has_room;
  logic                                           accept;
  logic [$clog2(replay_pkg::MAX_PKT_BEATS+1)-1:0] beat_cnt;

  // Fill level of the queue named by the waiting first beat
  assign used_words = tails[in_beat.qid] - heads[in_beat.qid];
  assign has_room   = (replay_pkg::QUEUE_DEPTH - used_words) >= replay_pkg::MAX_PKT_BEATS;

  // Words already held in the queue being written
  assign cur_used = tails[cur_qid] - heads[cur_qid];

  // Decision cycle holds the source off
  assign in_ready = (state != ST_DECIDE);
  assign accept   = in_valid && in_ready;

  always_comb begin
    wr_req.valid     = accept && (state == ST_STORE);
    wr_req.addr      = {cur_qid, tails[cur_qid][replay_pkg::OFFSET_W-1:0]};
    wr_req.word.data = in_beat.data;
    wr_req.word.last = in_beat.last;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_DECIDE;
      cur_qid  <= '0;
      tails    <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_DECIDE: begin
          beat_cnt <= '0;
          if (in_valid) begin
            cur_qid <= in_beat.qid;
            if (has_room) begin
              state <= ST_STORE;
            end else begin
              state <= ST_DROP;
            end
          end
        end
        ST_STORE, ST_DROP: begin
          if (accept) begin
            // Only stored beats move the tail
            if (state == ST_STORE) begin
              tails[cur_qid] <= tails[cur_qid] + 1'b1;
              beat_cnt       <= beat_cnt + 1'b1;
            end
            if (in_beat.last) begin
              state <= ST_DECIDE;
            end
          end
        end
        default: begin
          state <= ST_DECIDE;
        end
      endcase
    end
  end

  // Region room was reserved for at most MAX_PKT_BEATS words
  assert property (@(posedge clk) disable iff (rst)
    wr_req.valid |-> beat_cnt < replay_pkg::MAX_PKT_BEATS)
    else $error("Stored packet longer than MAX_PKT_BEATS");

  // Admission keeps every write inside its region
  assert property (@(posedge clk) disable iff (rst)
    wr_req.valid |-> cur_used < replay_pkg::QUEUE_DEPTH)
    else $error("Write would overrun unread words in the region");

endmodule

`default_nettype wire

/* verilog/replay_buffer_top.sv */
`timescale 1ns/100ps
`default_nettype none

module replay_buffer_top (
  input  wire                    clk,
  input  wire                    rst,
  input  wire replay_pkg::beat_t in_beat,
  input  wire                    in_valid,
  output logic                   in_ready,
  input  wire                    replay_en,
  output replay_pkg::beat_t      out_beat,
  output logic                   out_valid,
  input  wire                    out_ready
);

  replay_pkg::mem_wr_req_t wr_req;
  replay_pkg::mem_rd_req_t rd_req;
  replay_pkg::ptr_vec_t    tails;
  replay_pkg::ptr_vec_t    heads;
  replay_pkg::mem_word_t   rd_word;
  logic                    rd_grant;

  pkt_writer u_writer (
    .clk      (clk),
    .rst      (rst),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .heads    (heads),
    .wr_req   (wr_req),
    .tails    (tails)
  );

  pkt_reader u_reader (
    .clk       (clk),
    .rst       (rst),
    .replay_en (replay_en),
    .tails     (tails),
    .heads     (heads),
    .rd_req    (rd_req),
    .rd_grant  (rd_grant),
    .rd_word   (rd_word),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  mem_port_arbiter u_arbiter (
    .clk      (clk),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .rd_grant (rd_grant),
    .rd_word  (rd_word)
  );

endmodule

`default_nettype wire

/* verilog/replay_pkg.sv */
`default_nettype none

package replay_pkg;

  // Queue and memory geometry
  localparam int NUM_QUEUES    = 4;
  localparam int QID_W         = 2;
  localparam int DATA_W        = 32;
  localparam int QUEUE_DEPTH   = 64;
  localparam int OFFSET_W      = 6;
  localparam int PTR_W         = OFFSET_W + 1;
  localparam int ADDR_W        = QID_W + OFFSET_W;

  // Admission needs this many free words
  localparam int MAX_PKT_BEATS = 16;

  typedef struct packed {
    logic [QID_W-1:0]  qid;
    logic [DATA_W-1:0] data;
    logic              last;
  } beat_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } mem_word_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    mem_word_t         word;
  } mem_wr_req_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } mem_rd_req_t;

  // One pointer per queue, top bit is the wrap bit
  typedef logic [NUM_QUEUES-1:0][PTR_W-1:0] ptr_vec_t;

endpackage

`default_nettype wire
